//--- c51_macros.svh
`ifndef C51_MACROS_SVH
`define C51_MACROS_SVH

// code address bus
`define C51_PC_W      16

// data byte, accumulator and ROM byte
`define C51_DATA_W    8

// internal data RAM address
`define C51_RAM_AW    8

// program counter after reset or restart
`define C51_RESET_PC  16'h0000

`endif

//--- c51_pkg.sv
`include "c51_macros.svh"
`default_nettype none

package c51_pkg;

    // register-form view, rrr in the low three bits
    typedef struct packed {
        logic [4:0] group;
        logic [2:0] rn;
    } c51_reg_form_s;

    typedef union packed {
        logic [`C51_DATA_W-1:0] raw;
        c51_reg_form_s          rf;
    } c51_opcode_u;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_ADDC, ALU_SUBB, ALU_INC, ALU_DEC, ALU_ANL, ALU_ORL,
        ALU_XRL, ALU_CLR, ALU_CPL, ALU_RL, ALU_RLC, ALU_RR, ALU_RRC, ALU_SWAP
    } c51_alu_op_e;

    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_REG,
        SRC_IMM
    } c51_src_e;

    typedef struct packed {
        logic       cy;
        logic       ac;
        logic       f0;
        logic [1:0] rs;
        logic       ov;
        logic       ud;
        logic       p;
    } c51_psw_s;

    function automatic c51_alu_op_e c51_decode(input c51_opcode_u opc, output c51_src_e src,
                                               output logic wr_rn);
        c51_alu_op_e alu;
        alu   = ALU_NOP;
        src   = SRC_NONE;
        wr_rn = 1'b0;
        if (opc.raw[3]) begin
            case (opc.rf.group)
                5'b00001: alu = ALU_INC;
                5'b00011: alu = ALU_DEC;
                5'b00101: alu = ALU_ADD;
                5'b00111: alu = ALU_ADDC;
                5'b10011: alu = ALU_SUBB;
                5'b01001: alu = ALU_ORL;
                5'b01011: alu = ALU_ANL;
                5'b01101: alu = ALU_XRL;
                default:  alu = ALU_NOP;
            endcase
            // INC Rn and DEC Rn also read their register
            if (alu != ALU_NOP) src = SRC_REG;
            wr_rn = (alu == ALU_INC) || (alu == ALU_DEC);
        end else begin
            case (opc.raw)
                8'h04:   alu = ALU_INC;
                8'h14:   alu = ALU_DEC;
                8'h24:   alu = ALU_ADD;
                8'h34:   alu = ALU_ADDC;
                8'h94:   alu = ALU_SUBB;
                8'h44:   alu = ALU_ORL;
                8'h54:   alu = ALU_ANL;
                8'h64:   alu = ALU_XRL;
                8'hE4:   alu = ALU_CLR;
                8'hF4:   alu = ALU_CPL;
                8'h23:   alu = ALU_RL;
                8'h33:   alu = ALU_RLC;
                8'h03:   alu = ALU_RR;
                8'h13:   alu = ALU_RRC;
                8'hC4:   alu = ALU_SWAP;
                default: alu = ALU_NOP;
            endcase
            // binary ops outside the register form are the A,#data variants
            if (alu inside {ALU_ADD, ALU_ADDC, ALU_SUBB, ALU_ANL, ALU_ORL, ALU_XRL}) begin
                src = SRC_IMM;
            end
        end
        return alu;
    endfunction

endpackage

`default_nettype wire

//--- c51_op_if.sv
`default_nettype none

interface c51_op_if;

    // slot A, the opcode on the ROM bus this cycle
    logic                 slot_a_rd;
    logic [2:0]           slot_a_rn;

    // slot B, the opcode executing this cycle
    c51_pkg::c51_alu_op_e op_b;
    c51_pkg::c51_src_e    src_b;
    logic                 wr_rn_b;
    logic [2:0]           rn_b;

    modport fetch (
        output slot_a_rd,
        output slot_a_rn,
        output op_b,
        output src_b,
        output wr_rn_b,
        output rn_b
    );

    modport user (
        input slot_a_rd,
        input slot_a_rn,
        input op_b,
        input src_b,
        input wr_rn_b,
        input rn_b
    );

endinterface

`default_nettype wire

//--- c51_fetch.sv
`include "c51_macros.svh"
`default_nettype none

module c51_fetch (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cpu_restart,
    input  logic                   work_en,
    output logic                   rom_en,
    output logic [`C51_PC_W-1:0]   rom_addr,
    input  logic [`C51_DATA_W-1:0] rom_byte,
    output logic [`C51_DATA_W-1:0] imm,
    c51_op_if.fetch                op
);

    logic [`C51_PC_W-1:0] pc;
    // bit 0 slot A holds an opcode, bit 1 slot B holds an opcode
    logic [1:0]           slot_vld;
    c51_pkg::c51_opcode_u opc_a;
    c51_pkg::c51_opcode_u opc_b;
    c51_pkg::c51_alu_op_e op_a;
    c51_pkg::c51_src_e    src_a;
    logic                 wr_rn_a;
    logic                 two_byte_a;
    c51_pkg::c51_alu_op_e op_b_q;
    c51_pkg::c51_src_e    src_b_q;
    logic                 wr_rn_b_q;

    assign rom_en   = work_en;
    assign rom_addr = pc;

    // immediate byte is on the ROM bus while its opcode sits in slot B
    assign imm = rom_byte;

    always_comb begin
        opc_a.raw = rom_byte;
        op_a      = c51_pkg::c51_decode(opc_a, src_a, wr_rn_a);
    end

    assign two_byte_a   = slot_vld[0] && (src_a == c51_pkg::SRC_IMM);
    assign op.slot_a_rd = slot_vld[0] && (src_a == c51_pkg::SRC_REG);
    assign op.slot_a_rn = opc_a.rf.rn;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= `C51_RESET_PC;
        end else if (cpu_restart) begin
            pc <= `C51_RESET_PC;
        end else if (work_en) begin
            pc <= pc + `C51_PC_W'(1);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_vld <= 2'b00;
        end else if (cpu_restart) begin
            slot_vld <= 2'b00;
        end else if (work_en) begin
            if (two_byte_a) begin
                // next ROM byte is the operand, not an opcode
                slot_vld <= 2'b10;
            end else begin
                slot_vld <= {slot_vld[0], 1'b1};
            end
        end
    end

    // slot B payload, qualified by slot_vld[1]
    always_ff @(posedge clk) begin
        if (work_en) begin
            opc_b     <= opc_a;
            op_b_q    <= op_a;
            src_b_q   <= src_a;
            wr_rn_b_q <= wr_rn_a;
        end
    end

    assign op.op_b    = slot_vld[1] ? op_b_q : c51_pkg::ALU_NOP;
    assign op.src_b   = slot_vld[1] ? src_b_q : c51_pkg::SRC_NONE;
    assign op.wr_rn_b = slot_vld[1] && wr_rn_b_q;
    assign op.rn_b    = opc_b.rf.rn;

endmodule

`default_nettype wire

//--- c51_mem_port.sv
`include "c51_macros.svh"
`default_nettype none

module c51_mem_port (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cpu_en,
    input  logic                   cpu_restart,
    output logic                   work_en,
    c51_op_if.user                 op,
    input  logic [`C51_DATA_W-1:0] wr_byte,
    output logic [`C51_DATA_W-1:0] operand,
    output logic                   ram_rd_en,
    output logic                   ram_wr_en,
    output logic [`C51_RAM_AW-1:0] ram_rd_addr,
    output logic [`C51_RAM_AW-1:0] ram_wr_addr,
    input  logic [`C51_DATA_W-1:0] ram_rd_byte,
    input  logic                   ram_rd_vld,
    output logic [`C51_DATA_W-1:0] ram_wr_byte
);

    logic                   rd_wait;
    logic                   fwd_hit;
    logic                   fwd_vld;
    logic [`C51_DATA_W-1:0] fwd_byte;

    // whole pipeline freezes until the RAM answers
    assign work_en = (rd_wait && !ram_rd_vld) ? 1'b0 : cpu_en;

    // bank 0 only, RS reads as zero
    assign ram_rd_addr = {{(`C51_RAM_AW-3){1'b0}}, op.slot_a_rn};
    assign ram_wr_addr = {{(`C51_RAM_AW-3){1'b0}}, op.rn_b};

    // slot A reads what slot B writes in the same cycle
    assign fwd_hit = op.slot_a_rd && op.wr_rn_b && (ram_rd_addr == ram_wr_addr);

    assign ram_rd_en   = work_en && !cpu_restart && op.slot_a_rd && !fwd_hit;
    assign ram_wr_en   = work_en && op.wr_rn_b;
    assign ram_wr_byte = wr_byte;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_wait <= 1'b0;
        end else if (cpu_restart) begin
            rd_wait <= 1'b0;
        end else if (work_en) begin
            if (ram_rd_en) begin
                rd_wait <= 1'b1;
            end else if (ram_rd_vld) begin
                rd_wait <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fwd_vld <= 1'b0;
        end else if (cpu_restart) begin
            fwd_vld <= 1'b0;
        end else if (work_en) begin
            fwd_vld <= fwd_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (work_en && fwd_hit) begin
            fwd_byte <= wr_byte;
        end
    end

    // register byte for the opcode now in slot B
    assign operand = fwd_vld ? fwd_byte : ram_rd_byte;

endmodule

`default_nettype wire

//--- c51_execute.sv
`include "c51_macros.svh"
`default_nettype none

module c51_execute (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   work_en,
    c51_op_if.user                 op,
    input  logic [`C51_DATA_W-1:0] operand,
    input  logic [`C51_DATA_W-1:0] imm,
    output logic [`C51_DATA_W-1:0] wr_byte,
    output logic [`C51_DATA_W-1:0] acc,
    output c51_pkg::c51_psw_s      psw
);

    logic                   cy_q;
    logic                   ac_q;
    logic                   ov_q;
    logic [`C51_DATA_W-1:0] src_byte;
    logic [`C51_DATA_W-1:0] add_a;
    logic [`C51_DATA_W-1:0] add_b;
    logic                   add_c;
    logic                   sub;
    logic [4:0]             low_sum;
    logic [3:0]             mid_sum;
    logic [1:0]             top_sum;
    logic [`C51_DATA_W-1:0] sum;
    logic                   cy_out;
    logic                   ac_out;
    logic                   ov_out;

    always_comb begin
        case (op.src_b)
            c51_pkg::SRC_REG: src_byte = operand;
            c51_pkg::SRC_IMM: src_byte = imm;
            default:          src_byte = '0;
        endcase
    end

    // adder operand steering
    always_comb begin
        add_a = acc;
        add_b = src_byte;
        add_c = 1'b0;
        sub   = 1'b0;
        case (op.op_b)
            c51_pkg::ALU_ADDC: add_c = cy_q;
            c51_pkg::ALU_SUBB: begin
                add_c = cy_q;
                sub   = 1'b1;
            end
            c51_pkg::ALU_INC, c51_pkg::ALU_DEC: begin
                // Rn forms count the register byte instead of acc
                if (op.wr_rn_b) begin
                    add_a = operand;
                end
                add_b = '0;
                add_c = 1'b1;
                sub   = (op.op_b == c51_pkg::ALU_DEC);
            end
            default: ;
        endcase
    end

    // split after bit 3 for ac and after bit 6 for the carry into bit 7
    always_comb begin
        if (sub) begin
            low_sum = {1'b0, add_a[3:0]} - {1'b0, add_b[3:0]} - {4'b0, add_c};
            mid_sum = {1'b0, add_a[6:4]} - {1'b0, add_b[6:4]} - {3'b0, low_sum[4]};
            top_sum = {1'b0, add_a[7]} - {1'b0, add_b[7]} - {1'b0, mid_sum[3]};
        end else begin
            low_sum = {1'b0, add_a[3:0]} + {1'b0, add_b[3:0]} + {4'b0, add_c};
            mid_sum = {1'b0, add_a[6:4]} + {1'b0, add_b[6:4]} + {3'b0, low_sum[4]};
            top_sum = {1'b0, add_a[7]} + {1'b0, add_b[7]} + {1'b0, mid_sum[3]};
        end
    end

    assign sum    = {top_sum[0], mid_sum[2:0], low_sum[3:0]};
    assign ac_out = low_sum[4];
    assign cy_out = top_sum[1];
    assign ov_out = top_sum[1] ^ mid_sum[3];

    assign wr_byte = op.wr_rn_b ? sum : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc  <= '0;
            cy_q <= 1'b0;
            ac_q <= 1'b0;
            ov_q <= 1'b0;
        end else if (work_en) begin
            case (op.op_b)
                c51_pkg::ALU_ADD, c51_pkg::ALU_ADDC, c51_pkg::ALU_SUBB: begin
                    acc  <= sum;
                    cy_q <= cy_out;
                    ac_q <= ac_out;
                    ov_q <= ov_out;
                end
                c51_pkg::ALU_INC, c51_pkg::ALU_DEC: begin
                    // flags untouched
                    if (!op.wr_rn_b) begin
                        acc <= sum;
                    end
                end
                c51_pkg::ALU_ANL:  acc <= acc & src_byte;
                c51_pkg::ALU_ORL:  acc <= acc | src_byte;
                c51_pkg::ALU_XRL:  acc <= acc ^ src_byte;
                c51_pkg::ALU_CLR:  acc <= '0;
                c51_pkg::ALU_CPL:  acc <= ~acc;
                c51_pkg::ALU_RL:   acc <= {acc[6:0], acc[7]};
                c51_pkg::ALU_RR:   acc <= {acc[0], acc[7:1]};
                c51_pkg::ALU_SWAP: acc <= {acc[3:0], acc[7:4]};
                c51_pkg::ALU_RLC: begin
                    acc  <= {acc[6:0], cy_q};
                    cy_q <= acc[7];
                end
                c51_pkg::ALU_RRC: begin
                    acc  <= {cy_q, acc[7:1]};
                    cy_q <= acc[0];
                end
                default: ;
            endcase
        end
    end

    // no bank switching or user flags, parity follows acc
    always_comb begin
        psw    = '0;
        psw.cy = cy_q;
        psw.ac = ac_q;
        psw.ov = ov_q;
        psw.p  = ^acc;
    end

endmodule

`default_nettype wire

//--- c51_core.sv
`include "c51_macros.svh"
`default_nettype none

module c51_core (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cpu_en,
    input  logic                   cpu_restart,
    output logic                   rom_en,
    output logic [`C51_PC_W-1:0]   rom_addr,
    input  logic [`C51_DATA_W-1:0] rom_byte,
    output logic                   ram_rd_en,
    output logic [`C51_RAM_AW-1:0] ram_rd_addr,
    input  logic [`C51_DATA_W-1:0] ram_rd_byte,
    input  logic                   ram_rd_vld,
    output logic                   ram_wr_en,
    output logic [`C51_RAM_AW-1:0] ram_wr_addr,
    output logic [`C51_DATA_W-1:0] ram_wr_byte,
    output logic [`C51_DATA_W-1:0] acc,
    output logic [`C51_DATA_W-1:0] psw
);

    logic                   work_en;
    logic [`C51_DATA_W-1:0] imm;
    logic [`C51_DATA_W-1:0] operand;
    logic [`C51_DATA_W-1:0] wr_byte;

    c51_op_if u_op_if ();

    c51_fetch u_fetch (
        .clk         (clk),
        .rst         (rst),
        .cpu_restart (cpu_restart),
        .work_en     (work_en),
        .rom_en      (rom_en),
        .rom_addr    (rom_addr),
        .rom_byte    (rom_byte),
        .imm         (imm),
        .op          (u_op_if.fetch)
    );

    c51_mem_port u_mem_port (
        .clk         (clk),
        .rst         (rst),
        .cpu_en      (cpu_en),
        .cpu_restart (cpu_restart),
        .work_en     (work_en),
        .op          (u_op_if.user),
        .wr_byte     (wr_byte),
        .operand     (operand),
        .ram_rd_en   (ram_rd_en),
        .ram_wr_en   (ram_wr_en),
        .ram_rd_addr (ram_rd_addr),
        .ram_wr_addr (ram_wr_addr),
        .ram_rd_byte (ram_rd_byte),
        .ram_rd_vld  (ram_rd_vld),
        .ram_wr_byte (ram_wr_byte)
    );

    // psw leaves as a plain byte, cy in bit 7
    c51_execute u_execute (
        .clk     (clk),
        .rst     (rst),
        .work_en (work_en),
        .op      (u_op_if.user),
        .operand (operand),
        .imm     (imm),
        .wr_byte (wr_byte),
        .acc     (acc),
        .psw     (psw)
    );

endmodule

`default_nettype wire

//--- c51_assert.sv
`default_nettype none

module c51_assert (
    input logic clk,
    input logic rst,
    input logic cpu_en,
    input logic rom_en,
    input logic ram_rd_en,
    input logic ram_wr_en,
    input logic ram_rd_vld
);
    timeunit 1ns;
    timeprecision 1ps;

    // outstanding RAM read, seen from the pins
    logic rd_pending;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_pending <= 1'b0;
        end else if (ram_rd_en) begin
            rd_pending <= 1'b1;
        end else if (ram_rd_vld) begin
            rd_pending <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !cpu_en |-> !ram_rd_en && !ram_wr_en)
        else $error("RAM access while cpu_en is low");

    assert property (@(posedge clk) disable iff (rst) rd_pending && !ram_rd_vld |-> !rom_en)
        else $error("ROM fetch while a RAM read is outstanding");

endmodule

bind c51_core c51_assert u_assert (
    .clk        (clk),
    .rst        (rst),
    .cpu_en     (cpu_en),
    .rom_en     (rom_en),
    .ram_rd_en  (ram_rd_en),
    .ram_wr_en  (ram_wr_en),
    .ram_rd_vld (ram_rd_vld)
);

`default_nettype wire

//--- tb_c51.sv
`include "c51_macros.svh"
`default_nettype none

module tb_c51;
    timeunit 1ns;
    timeprecision 1ps;

    logic                   clk;
    logic                   rst;
    logic                   cpu_en;
    logic                   cpu_restart;
    logic                   rom_en;
    logic [`C51_PC_W-1:0]   rom_addr;
    logic [`C51_DATA_W-1:0] rom_byte;
    logic                   ram_rd_en;
    logic [`C51_RAM_AW-1:0] ram_rd_addr;
    logic [`C51_DATA_W-1:0] ram_rd_byte;
    logic                   ram_rd_vld;
    logic                   ram_wr_en;
    logic [`C51_RAM_AW-1:0] ram_wr_addr;
    logic [`C51_DATA_W-1:0] ram_wr_byte;
    logic [`C51_DATA_W-1:0] acc;
    logic [`C51_DATA_W-1:0] psw;

    logic [7:0]  rom [0:255];
    logic [7:0]  ram [0:255];
    logic [7:0]  ram_init [0:255];
    logic [7:0]  m_ram [0:7];
    logic [7:0]  m_acc;
    logic        m_cy;
    logic        m_ac;
    logic        m_ov;
    logic [7:0]  prog_len;
    logic [31:0] rnd;
    logic [31:0] lat;
    logic        pend;
    logic [1:0]  cnt;
    logic [7:0]  pend_addr;
    integer      seed;
    integer      errors;
    integer      checks;
    integer      raw_reads;

    c51_core u_c51_core (
        .clk         (clk),
        .rst         (rst),
        .cpu_en      (cpu_en),
        .cpu_restart (cpu_restart),
        .rom_en      (rom_en),
        .rom_addr    (rom_addr),
        .rom_byte    (rom_byte),
        .ram_rd_en   (ram_rd_en),
        .ram_rd_addr (ram_rd_addr),
        .ram_rd_byte (ram_rd_byte),
        .ram_rd_vld  (ram_rd_vld),
        .ram_wr_en   (ram_wr_en),
        .ram_wr_addr (ram_wr_addr),
        .ram_wr_byte (ram_wr_byte),
        .acc         (acc),
        .psw         (psw)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // code ROM, byte one cycle after the request
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_byte <= 8'h00;
        end else if (rom_en) begin
            rom_byte <= rom[rom_addr[7:0]];
        end
    end

    // data RAM with 1 to 3 cycles of read latency
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 256; i++) begin
                ram[i] <= ram_init[i];
            end
            ram_rd_vld  <= 1'b0;
            ram_rd_byte <= 8'h00;
            pend        <= 1'b0;
            cnt         <= 2'd0;
            pend_addr   <= 8'h00;
        end else begin
            ram_rd_vld <= 1'b0;
            if (ram_wr_en) begin
                ram[ram_wr_addr] <= ram_wr_byte;
            end
            if (pend) begin
                if (cnt == 2'd1) begin
                    ram_rd_vld  <= 1'b1;
                    ram_rd_byte <= ram[pend_addr];
                    pend        <= 1'b0;
                end else begin
                    cnt <= cnt - 2'd1;
                end
            end
            if (ram_rd_en) begin
                rnd = $random(seed);
                lat = rnd % 32'd3;
                if (lat == 32'd0) begin
                    ram_rd_vld  <= 1'b1;
                    ram_rd_byte <= ram[ram_rd_addr];
                end else begin
                    pend      <= 1'b1;
                    cnt       <= lat[1:0];
                    pend_addr <= ram_rd_addr;
                end
            end
        end
    end

    // a read colliding with a write to the same register should be forwarded
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            raw_reads <= 0;
        end else if (ram_rd_en && ram_wr_en && ram_rd_addr == ram_wr_addr) begin
            raw_reads <= raw_reads + 1;
        end
    end

    task automatic check(input string what, input logic [15:0] got, input logic [15:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // 8051 result rules for the accumulator and flags
    task automatic model_op(input c51_pkg::c51_alu_op_e alu, input logic [7:0] s);
        logic [8:0] r;
        logic [4:0] lo;
        logic [7:0] lo7;
        logic [7:0] c8;
        logic       bit_out;
        c8 = {7'b0, (alu == c51_pkg::ALU_ADD) ? 1'b0 : m_cy};
        case (alu)
            c51_pkg::ALU_ADD, c51_pkg::ALU_ADDC, c51_pkg::ALU_SUBB: begin
                if (alu == c51_pkg::ALU_SUBB) begin
                    r   = {1'b0, m_acc} - {1'b0, s} - {1'b0, c8};
                    lo  = {1'b0, m_acc[3:0]} - {1'b0, s[3:0]} - c8[4:0];
                    lo7 = {1'b0, m_acc[6:0]} - {1'b0, s[6:0]} - c8;
                end else begin
                    r   = {1'b0, m_acc} + {1'b0, s} + {1'b0, c8};
                    lo  = {1'b0, m_acc[3:0]} + {1'b0, s[3:0]} + c8[4:0];
                    lo7 = {1'b0, m_acc[6:0]} + {1'b0, s[6:0]} + c8;
                end
                m_cy  = r[8];
                m_ac  = lo[4];
                m_ov  = lo7[7] ^ r[8];
                m_acc = r[7:0];
            end
            c51_pkg::ALU_INC:  m_acc = m_acc + 8'd1;
            c51_pkg::ALU_DEC:  m_acc = m_acc - 8'd1;
            c51_pkg::ALU_ANL:  m_acc = m_acc & s;
            c51_pkg::ALU_ORL:  m_acc = m_acc | s;
            c51_pkg::ALU_XRL:  m_acc = m_acc ^ s;
            c51_pkg::ALU_CLR:  m_acc = 8'h00;
            c51_pkg::ALU_CPL:  m_acc = ~m_acc;
            c51_pkg::ALU_RL:   m_acc = {m_acc[6:0], m_acc[7]};
            c51_pkg::ALU_RR:   m_acc = {m_acc[0], m_acc[7:1]};
            c51_pkg::ALU_SWAP: m_acc = {m_acc[3:0], m_acc[7:4]};
            c51_pkg::ALU_RLC: begin
                bit_out = m_acc[7];
                m_acc   = {m_acc[6:0], m_cy};
                m_cy    = bit_out;
            end
            c51_pkg::ALU_RRC: begin
                bit_out = m_acc[0];
                m_acc   = {m_cy, m_acc[7:1]};
                m_cy    = bit_out;
            end
            default: ;
        endcase
    endtask

    task automatic emit(input logic [7:0] b);
        rom[prog_len] = b;
        prog_len = prog_len + 8'd1;
    endtask

    task automatic emit_imm(input logic [7:0] opc, input c51_pkg::c51_alu_op_e alu,
                            input logic [7:0] data);
        emit(opc);
        emit(data);
        model_op(alu, data);
    endtask

    task automatic emit_one(input logic [7:0] opc, input c51_pkg::c51_alu_op_e alu);
        emit(opc);
        model_op(alu, 8'h00);
    endtask

    task automatic emit_reg(input logic [7:0] opc, input c51_pkg::c51_alu_op_e alu);
        emit(opc);
        model_op(alu, m_ram[opc[2:0]]);
    endtask

    // INC Rn or DEC Rn
    task automatic emit_step(input logic [7:0] opc, input logic up);
        emit(opc);
        m_ram[opc[2:0]] = up ? m_ram[opc[2:0]] + 8'd1 : m_ram[opc[2:0]] - 8'd1;
    endtask

    task automatic set_reg(input int rn, input logic [7:0] v);
        ram_init[rn] = v;
        m_ram[rn]    = v;
    endtask

    task automatic start_test();
        for (int i = 0; i < 256; i++) begin
            rom[i]      = 8'h00;
            ram_init[i] = i[7:0] ^ 8'hA5;
        end
        for (int i = 0; i < 8; i++) begin
            m_ram[i] = ram_init[i];
        end
        prog_len = 8'h00;
        m_acc    = 8'h00;
        m_cy     = 1'b0;
        m_ac     = 1'b0;
        m_ov     = 1'b0;
    endtask

    task automatic wait_addr(input logic [15:0] limit);
        int n;
        n = 0;
        while (n < 2000) begin
            @(negedge clk);
            if (rom_addr >= limit) begin
                break;
            end
            n = n + 1;
        end
        if (n >= 2000) begin
            errors = errors + 1;
            $display("Timeout: rom_addr never reached %h", limit);
        end
    endtask

    // a RAM answer with no new read issued behind it
    task automatic wait_rd_idle();
        int n;
        n = 0;
        while (n < 100) begin
            @(negedge clk);
            if (ram_rd_vld && !ram_rd_en) begin
                break;
            end
            n = n + 1;
        end
        if (n >= 100) begin
            errors = errors + 1;
            $display("Timeout: no completed RAM read without a new request");
        end
    endtask

    task automatic run_program();
        @(posedge clk);
        rst    <= 1'b1;
        cpu_en <= 1'b0;
        repeat (8) @(posedge clk);
        rst    <= 1'b0;
        cpu_en <= 1'b1;
        wait_addr({8'h00, prog_len} + 16'd3);
    endtask

    task automatic check_state(input logic all_flags);
        check("acc", {8'h00, acc}, {8'h00, m_acc});
        check("cy", {15'b0, psw[7]}, {15'b0, m_cy});
        // f0, rs and ud have no source in this core
        check("psw f0 rs ud", {12'b0, psw[5:3], psw[1]}, 16'h0000);
        if (all_flags) begin
            check("ac", {15'b0, psw[6]}, {15'b0, m_ac});
            check("ov", {15'b0, psw[2]}, {15'b0, m_ov});
            check("p", {15'b0, psw[0]}, {15'b0, ^m_acc});
        end
    endtask

    task automatic test_imm_arith();
        start_test();
        emit_imm(8'h24, c51_pkg::ALU_ADD, 8'h7F);
        emit_imm(8'h24, c51_pkg::ALU_ADD, 8'h01);
        emit_imm(8'h34, c51_pkg::ALU_ADDC, 8'h80);
        emit_imm(8'h34, c51_pkg::ALU_ADDC, 8'h0F);
        emit_imm(8'h94, c51_pkg::ALU_SUBB, 8'h20);
        emit_imm(8'h94, c51_pkg::ALU_SUBB, 8'hF0);
        run_program();
        check_state(1'b1);
    endtask

    task automatic test_logic_unary();
        start_test();
        emit_imm(8'h24, c51_pkg::ALU_ADD, 8'hF5);
        emit_imm(8'h54, c51_pkg::ALU_ANL, 8'h3C);
        emit_imm(8'h44, c51_pkg::ALU_ORL, 8'h81);
        emit_imm(8'h64, c51_pkg::ALU_XRL, 8'hFF);
        emit_one(8'h04, c51_pkg::ALU_INC);
        emit_one(8'h14, c51_pkg::ALU_DEC);
        emit_one(8'h23, c51_pkg::ALU_RL);
        emit_imm(8'h24, c51_pkg::ALU_ADD, 8'hC0);
        emit_one(8'h33, c51_pkg::ALU_RLC);
        emit_one(8'h03, c51_pkg::ALU_RR);
        emit_one(8'h13, c51_pkg::ALU_RRC);
        emit_one(8'hC4, c51_pkg::ALU_SWAP);
        emit_one(8'hE4, c51_pkg::ALU_CLR);
        emit_imm(8'h44, c51_pkg::ALU_ORL, 8'h96);
        emit_one(8'hF4, c51_pkg::ALU_CPL);
        run_program();
        check_state(1'b0);
    endtask

    task automatic test_reg_operands();
        start_test();
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            set_reg(i, rnd[7:0]);
        end
        emit_reg(8'h28, c51_pkg::ALU_ADD);
        emit_reg(8'h39, c51_pkg::ALU_ADDC);
        emit_reg(8'h9A, c51_pkg::ALU_SUBB);
        emit_reg(8'h5B, c51_pkg::ALU_ANL);
        emit_reg(8'h4C, c51_pkg::ALU_ORL);
        emit_reg(8'h6D, c51_pkg::ALU_XRL);
        emit_reg(8'h2E, c51_pkg::ALU_ADD);
        emit_reg(8'h3F, c51_pkg::ALU_ADDC);
        run_program();
        check_state(1'b0);
    endtask

    task automatic test_inc_dec_rn();
        start_test();
        set_reg(5, 8'hFF);
        set_reg(6, 8'h00);
        set_reg(1, 8'h10);
        set_reg(2, 8'h80);
        emit_step(8'h0D, 1'b1);
        emit_step(8'h1E, 1'b0);
        // back to back on R1 goes through forwarding
        emit_step(8'h09, 1'b1);
        emit_step(8'h09, 1'b1);
        emit_step(8'h1A, 1'b0);
        run_program();
        check("R1", {8'h00, ram[1]}, {8'h00, m_ram[1]});
        check("R2", {8'h00, ram[2]}, {8'h00, m_ram[2]});
        check("R5", {8'h00, ram[5]}, {8'h00, m_ram[5]});
        check("R6", {8'h00, ram[6]}, {8'h00, m_ram[6]});
    endtask

    task automatic test_forwarding();
        start_test();
        set_reg(3, 8'h41);
        emit_step(8'h0B, 1'b1);
        emit_reg(8'h2B, c51_pkg::ALU_ADD);
        emit_step(8'h1B, 1'b0);
        emit_reg(8'h9B, c51_pkg::ALU_SUBB);
        run_program();
        check_state(1'b0);
        check("R3", {8'h00, ram[3]}, {8'h00, m_ram[3]});
        check("reads during write", raw_reads[15:0], 16'h0000);
    endtask

    task automatic test_control();
        logic [15:0] held;
        int          n;
        start_test();
        // INC Rn keeps both RAM ports busy, INC A leaves a gap after each answer
        for (int i = 0; i < 12; i++) begin
            emit_step({5'b00001, i[2:0]}, 1'b1);
            emit_one(8'h04, c51_pkg::ALU_INC);
        end
        @(posedge clk);
        rst    <= 1'b1;
        cpu_en <= 1'b0;
        repeat (8) @(posedge clk);
        rst    <= 1'b0;
        cpu_en <= 1'b1;
        wait_addr(16'd6);
        wait_rd_idle();
        @(posedge clk);
        cpu_en <= 1'b0;
        @(negedge clk);
        held = rom_addr;
        repeat (10) begin
            @(negedge clk);
            check("rom_en while disabled", {15'b0, rom_en}, 16'h0000);
            check("ram_rd_en while disabled", {15'b0, ram_rd_en}, 16'h0000);
            check("ram_wr_en while disabled", {15'b0, ram_wr_en}, 16'h0000);
            check("rom_addr hold", rom_addr, held);
        end
        @(posedge clk);
        cpu_en <= 1'b1;
        wait_rd_idle();
        @(posedge clk);
        cpu_restart <= 1'b1;
        @(posedge clk);
        cpu_restart <= 1'b0;
        n = 0;
        while (n < 100) begin
            @(negedge clk);
            if (rom_en) begin
                break;
            end
            n = n + 1;
        end
        if (n >= 100) begin
            errors = errors + 1;
            $display("Timeout: no ROM fetch after restart");
        end
        check("rom_addr after restart", rom_addr, 16'h0000);
    endtask

    initial begin
        rst         = 1'b1;
        cpu_en      = 1'b0;
        cpu_restart = 1'b0;
        seed        = 54;
        errors      = 0;
        checks      = 0;
        test_imm_arith();
        test_logic_unary();
        test_reg_operands();
        test_inc_dec_rn();
        test_forwarding();
        test_control();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
c51_pkg.sv
c51_op_if.sv
c51_fetch.sv
c51_mem_port.sv
c51_execute.sv
c51_core.sv
c51_assert.sv
tb_c51.sv

//--- run_sim.sh
#!/bin/sh
# build and run the c51 core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_c51 -f vlog.f -o sim_c51
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_c51 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "%Error" sim.log; then
    echo "FAIL: assertion or runtime error in log"
    exit 1
fi

if grep -q "All tests passed!" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
